//--- Makefile
TOP = tb_mips_system

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- list.f
+incdir+verification
verilog/mips_pkg.sv
verilog/decode_if.sv
verilog/instr_ram.sv
verilog/data_ram.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/cpu_core.sv
verilog/mips_system.sv
verification/tb_mips_system.sv

//--- verification/tb_programs.svh
`default_nettype none

// one row per program: words fetched from the reset vector, word count and
// the value v0 must hold once the core has halted through jr r0
localparam int num_programs = 8;
localparam int max_words = 8;

localparam int prog_len [num_programs] = '{7, 2, 4, 6, 8, 8, 7, 6};

localparam logic [31:0] expect_v0 [num_programs] = '{
    32'hABCC_FFF0,  // (0xABCD0000 | 0x1224) - 0x1234
    32'hFFFF_ABCD,  // addiu sign extends its immediate
    32'h0000_0BC0,  // 0xFFFFABCD & 0x0FF0
    32'h8765_4321,  // sw then lw of the same word
    32'hFFFF_FFEC,  // lb byte 2 (0x65) plus lb byte 3 (0x87 sign extended)
    32'h7ABC_4321,  // sh into the upper half, lower half kept
    32'h0000_0011,  // 0x10 plus 1, the skipped 0x100 never added
    32'h0000_0035   // 5 plus 0x30, the jumped over words never run
};

localparam logic [31:0] prog_words [num_programs][max_words] = '{
    // addiu r8 0x1234, addiu r9 -16, addu r10, lui r11, or r12, subu r2, jr r0
    '{32'h2408_1234, 32'h2409_FFF0, 32'h0109_5021, 32'h3C0B_ABCD,
      32'h016A_6025, 32'h0188_1023, 32'h0000_0008, 32'h0000_0000},
    // addiu r2 0xABCD, jr r0
    '{32'h2402_ABCD, 32'h0000_0008, 32'h0000_0000, 32'h0000_0000,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
    // addiu r2 0xABCD, addiu r3 0x0FF0, and r2 r2 r3, jr r0
    '{32'h2402_ABCD, 32'h2403_0FF0, 32'h0043_1024, 32'h0000_0008,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
    // r8 = 0x400, r9 = 0x87654321, sw r9 0x80(r8), lw r2 0x80(r8), jr r0
    '{32'h2408_0400, 32'h3C09_8765, 32'h2529_4321, 32'hAD09_0080,
      32'h8D02_0080, 32'h0000_0008, 32'h0000_0000, 32'h0000_0000},
    // store the word, lb r3 0x82(r8), lb r4 0x83(r8), addu r2 r3 r4, jr r0
    '{32'h2408_0400, 32'h3C09_8765, 32'h2529_4321, 32'hAD09_0080,
      32'h8103_0082, 32'h8104_0083, 32'h0064_1021, 32'h0000_0008},
    // store the word, addiu r10 0x7ABC, sh r10 0x82(r8), lw r2 0x80(r8), jr r0
    '{32'h2408_0400, 32'h3C09_8765, 32'h2529_4321, 32'hAD09_0080,
      32'h240A_7ABC, 32'hA50A_0082, 32'h8D02_0080, 32'h0000_0008},
    // r8 = 1, r2 = 0x10, bne taken over +0x100, beq not taken into +1, jr r0
    '{32'h2408_0001, 32'h2402_0010, 32'h1500_0001, 32'h2442_0100,
      32'h1100_0001, 32'h2442_0001, 32'h0000_0008, 32'h0000_0000},
    // r2 = 5, j to word 4, two skipped adds, addiu r2 0x30, jr r0
    '{32'h2402_0005, 32'h0BF0_0004, 32'h2442_0100, 32'h2442_0200,
      32'h2442_0030, 32'h0000_0008, 32'h0000_0000, 32'h0000_0000}
};

`default_nettype wire

//--- verification/tb_mips_system.sv
`timescale 1ns/10ps
`include "tb_programs.svh"
`default_nettype none

module tb_mips_system import mips_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        active;
    logic [31:0] register_v0;

    int errors;
    int checks;
    int cycle_count;
    int cycle_limit;

    mips_system dut (
        .clk, .rst_n, .load_en, .load_addr, .load_data, .active, .register_v0
    );

    always #2 clk = ~clk;

    // every row gets its program length four times over plus some slack
    function automatic int timeout_cycles();
        int total;
        total = 0;
        for (int row = 0; row < num_programs; row++) begin
            total += prog_len[row] * 4 + 10;
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // reset stays low while the program goes in and for 3 more cycles
    task automatic reset_and_load(input int row);
        @(negedge clk);
        rst_n = 1'b0;
        for (int w = 0; w < prog_len[row]; w++) begin
            load_en   = 1'b1;
            load_addr = reset_vector + 32'(4 * w);
            load_data = prog_words[row][w];
            @(negedge clk);
        end
        load_en = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic run_program(input int row);
        reset_and_load(row);
        check_value("active", 32'(active), 32'h1);
        while (active) @(negedge clk);
        check_value("register_v0", register_v0, expect_v0[row]);
        // halted core must stay idle with v0 frozen
        repeat (5) begin
            @(negedge clk);
            check_value("active", 32'(active), 32'h0);
            check_value("register_v0", register_v0, expect_v0[row]);
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the core never halted", cycle_count);
            $display("checks %0d errors %0d", checks, errors + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        load_en     = 1'b0;
        load_addr   = 32'h0;
        load_data   = 32'h0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        cycle_limit = timeout_cycles();
        for (int row = 0; row < num_programs; row++) begin
            run_program(row);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output logic        active,
    decode_if.core      ctl,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [4:0]  read_a,
    output logic [4:0]  read_b,
    input  logic [31:0] value_a,
    input  logic [31:0] value_b,
    output logic        write_en,
    output logic [4:0]  write_addr,
    output logic [31:0] write_data,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic [3:0]  data_byteenable,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] load_value;
    logic [7:0]  load_byte;
    logic        branch_taken;

    assign ctl.instr     = instr_readdata;
    assign instr_address = pc;
    assign read_a        = instr_readdata[25:21];
    assign read_b        = instr_readdata[20:16];

    // the core stops once the pc has reached location 0
    assign active = (pc != 32'h0);

    assign imm_ext = ctl.sign_ext ? {{16{instr_readdata[15]}}, instr_readdata[15:0]}
                                  : {16'h0, instr_readdata[15:0]};
    assign alu_b   = ctl.use_imm ? imm_ext : value_b;

    always_comb begin
        case (ctl.alu_op)
            alu_sub: alu_result = value_a - alu_b;
            alu_and: alu_result = value_a & alu_b;
            alu_or:  alu_result = value_a | alu_b;
            alu_lui: alu_result = {alu_b[15:0], 16'h0};
            default: alu_result = value_a + alu_b;
        endcase
    end

    assign pc_plus4     = pc + 32'd4;
    assign branch_taken = (ctl.branch_eq && value_a == value_b) ||
                          (ctl.branch_ne && value_a != value_b);

    // no delay slot, the target is fetched on the very next cycle
    always_comb begin
        if (ctl.jump_reg) begin
            next_pc = value_a;
        end else if (ctl.jump) begin
            next_pc = {pc_plus4[31:28], instr_readdata[25:0], 2'b00};
        end else if (branch_taken) begin
            next_pc = pc_plus4 + {{14{instr_readdata[15]}}, instr_readdata[15:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_vector;
        end else if (active) begin
            pc <= next_pc;
        end
    end

    // store lane steering, little endian
    assign data_address = alu_result;
    always_comb begin
        case (ctl.mem_size)
            mem_byte: begin
                data_byteenable = 4'b0001 << data_address[1:0];
                data_writedata  = {4{value_b[7:0]}};
            end
            mem_half: begin
                data_byteenable = data_address[1] ? 4'b1100 : 4'b0011;
                data_writedata  = {2{value_b[15:0]}};
            end
            mem_word: begin
                data_byteenable = 4'b1111;
                data_writedata  = value_b;
            end
            default: begin
                data_byteenable = 4'b0000;
                data_writedata  = value_b;
            end
        endcase
    end
    assign data_write = ctl.mem_write && active && rst_n;

    // lb picks the addressed lane and sign extends it
    assign load_byte  = data_readdata[8*data_address[1:0] +: 8];
    assign load_value = (ctl.mem_size == mem_byte) ? {{24{load_byte[7]}}, load_byte}
                                                   : data_readdata;

    assign write_en   = ctl.reg_write && active;
    assign write_addr = ctl.dest_is_rt ? instr_readdata[20:16] : instr_readdata[15:11];
    assign write_data = ctl.mem_read ? load_value : alu_result;

    a_mem_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (active && (ctl.mem_read || ctl.mem_write)) |->
            ((ctl.mem_size != mem_half || !data_address[0]) &&
             (ctl.mem_size != mem_word || data_address[1:0] == 2'b00))
    ) else $error("misaligned data access at %h", data_address);

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram import mips_pkg::*; (
    input  logic        clk,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic [3:0]  data_byteenable,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);

    logic [31:0] mem [dmem_words];

    logic [31:0] offset;
    logic        in_range;
    logic [dmem_index_w-1:0] index;

    // addresses below the base wrap to large offsets and fall out of range
    assign offset   = data_address - dmem_base;
    assign in_range = (offset < 32'(dmem_words * 4));
    assign index    = offset[dmem_index_w+1:2];

    // reads outside the window return zero
    assign data_readdata = in_range ? mem[index] : 32'h0;

    always_ff @(posedge clk) begin
        if (data_write && in_range) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (data_byteenable[lane]) begin
                    mem[index][8*lane +: 8] <= data_writedata[8*lane +: 8];
                end
            end
        end
    end

    a_write_has_lanes: assert property (
        @(posedge clk) data_write |-> (data_byteenable != 4'b0000)
    ) else $error("data_ram write at %h with no byte lanes enabled", data_address);

endmodule

`default_nettype wire

//--- verilog/decode_if.sv
`timescale 1ns/10ps
`default_nettype none

interface decode_if import mips_pkg::*; ();

    logic [31:0] instr;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        sign_ext;
    logic        reg_write;
    logic        dest_is_rt;
    logic        mem_read;
    logic        mem_write;
    mem_size_e   mem_size;
    logic        branch_eq;
    logic        branch_ne;
    logic        jump;
    logic        jump_reg;

    modport decoder (
        input  instr,
        output alu_op, use_imm, sign_ext, reg_write, dest_is_rt, mem_read,
        output mem_write, mem_size, branch_eq, branch_ne, jump, jump_reg
    );

    modport core (
        output instr,
        input  alu_op, use_imm, sign_ext, reg_write, dest_is_rt, mem_read,
        input  mem_write, mem_size, branch_eq, branch_ne, jump, jump_reg
    );

endinterface

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder import mips_pkg::*; (
    decode_if.decoder dec
);

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(dec.instr[31:26]);
    assign funct  = funct_e'(dec.instr[5:0]);

    always_comb begin
        // no-op unless an encoding below matches
        dec.alu_op     = alu_add;
        dec.use_imm    = 1'b0;
        dec.sign_ext   = 1'b0;
        dec.reg_write  = 1'b0;
        dec.dest_is_rt = 1'b0;
        dec.mem_read   = 1'b0;
        dec.mem_write  = 1'b0;
        dec.mem_size   = mem_none;
        dec.branch_eq  = 1'b0;
        dec.branch_ne  = 1'b0;
        dec.jump       = 1'b0;
        dec.jump_reg   = 1'b0;

        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu: begin
                        dec.alu_op    = alu_add;
                        dec.reg_write = 1'b1;
                    end
                    fn_subu: begin
                        dec.alu_op    = alu_sub;
                        dec.reg_write = 1'b1;
                    end
                    fn_and: begin
                        dec.alu_op    = alu_and;
                        dec.reg_write = 1'b1;
                    end
                    fn_or: begin
                        dec.alu_op    = alu_or;
                        dec.reg_write = 1'b1;
                    end
                    fn_jr:   dec.jump_reg = 1'b1;
                    default: ;
                endcase
            end
            op_j:   dec.jump = 1'b1;
            op_beq: dec.branch_eq = 1'b1;
            op_bne: dec.branch_ne = 1'b1;
            op_addiu: begin
                dec.use_imm    = 1'b1;
                dec.sign_ext   = 1'b1;
                dec.reg_write  = 1'b1;
                dec.dest_is_rt = 1'b1;
            end
            op_lui: begin
                dec.alu_op     = alu_lui;
                dec.use_imm    = 1'b1;
                dec.reg_write  = 1'b1;
                dec.dest_is_rt = 1'b1;
            end
            // loads and stores share the base plus offset address path
            op_lb, op_lw, op_sh, op_sw: begin
                dec.use_imm  = 1'b1;
                dec.sign_ext = 1'b1;
                dec.mem_size = (opcode == op_lb) ? mem_byte :
                               (opcode == op_sh) ? mem_half : mem_word;
                if (opcode == op_lb || opcode == op_lw) begin
                    dec.mem_read   = 1'b1;
                    dec.reg_write  = 1'b1;
                    dec.dest_is_rt = 1'b1;
                end else begin
                    dec.mem_write = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/instr_ram.sv
`timescale 1ns/10ps
`default_nettype none

module instr_ram import mips_pkg::*; (
    input  logic        clk,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data
);

    logic [31:0] mem [imem_words];

    logic [31:0] fetch_offset;
    logic [31:0] load_offset;
    logic [imem_index_w-1:0] fetch_index;
    logic [imem_index_w-1:0] load_index;

    // boot region relative byte offsets, wrapped onto the array
    assign fetch_offset = instr_address - reset_vector;
    assign load_offset  = load_addr - reset_vector;
    assign fetch_index  = fetch_offset[imem_index_w+1:2];
    assign load_index   = load_offset[imem_index_w+1:2];

    // combinational fetch
    assign instr_readdata = mem[fetch_index];

    // program load port, one word per clock
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_index] <= load_data;
        end
    end

    a_load_aligned: assert property (
        @(posedge clk) load_en |-> (load_addr[1:0] == 2'b00)
    ) else $error("instr_ram load address %h is not word aligned", load_addr);

endmodule

`default_nettype wire

//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // boot region and memory map
    localparam logic [31:0] reset_vector = 32'hBFC00000;
    localparam int imem_words = 1024;
    localparam int dmem_words = 256;
    localparam logic [31:0] dmem_base = 32'h00000400;

    // word index widths for the two memories
    localparam int imem_index_w = $clog2(imem_words);
    localparam int dmem_index_w = $clog2(dmem_words);

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lb      = 6'h20,
        op_lw      = 6'h23,
        op_sh      = 6'h29,
        op_sw      = 6'h2b
    } opcode_e;

    // funct field of the special opcode
    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_byte,
        mem_half,
        mem_word
    } mem_size_e;

endpackage

`default_nettype wire

//--- verilog/mips_system.sv
`timescale 1ns/10ps
`default_nettype none

module mips_system (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    output logic        active,
    output logic [31:0] register_v0
);

    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [4:0]  read_a;
    logic [4:0]  read_b;
    logic [31:0] value_a;
    logic [31:0] value_b;
    logic        write_en;
    logic [4:0]  write_addr;
    logic [31:0] write_data;
    logic [31:0] data_address;
    logic        data_write;
    logic [3:0]  data_byteenable;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    // decoded control between decoder and datapath
    decode_if dif ();

    cpu_core u_core (
        .clk, .rst_n, .active, .ctl(dif.core),
        .instr_address, .instr_readdata,
        .read_a, .read_b, .value_a, .value_b,
        .write_en, .write_addr, .write_data,
        .data_address, .data_write, .data_byteenable, .data_writedata, .data_readdata
    );

    instr_decoder u_decoder (.dec(dif.decoder));

    reg_file u_regs (
        .clk, .rst_n, .read_a, .read_b, .value_a, .value_b,
        .write_en, .write_addr, .write_data, .register_v0
    );

    instr_ram u_iram (.clk, .instr_address, .instr_readdata, .load_en, .load_addr, .load_data);

    data_ram u_dram (
        .clk, .data_address, .data_write, .data_byteenable, .data_writedata, .data_readdata
    );

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  read_a,
    input  logic [4:0]  read_b,
    output logic [31:0] value_a,
    output logic [31:0] value_b,
    input  logic        write_en,
    input  logic [4:0]  write_addr,
    input  logic [31:0] write_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (write_en && write_addr != 5'd0) begin
            // r0 is never written
            regs[write_addr] <= write_data;
        end
    end

    assign value_a     = regs[read_a];
    assign value_b     = regs[read_b];
    assign register_v0 = regs[2];

    a_r0_zero: assert property (
        @(posedge clk) disable iff (!rst_n) regs[0] == 32'h0
    ) else $error("register 0 holds %h", regs[0]);

endmodule

`default_nettype wire
